// ==== rtl/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

    // first fetch address out of reset
    localparam logic [31:0] RESET_PC = 32'h1eceb000;

    // line geometry, fixed by the burst memory
    localparam int BEATS_PER_LINE   = 4;    // 64-bit beats per line
    localparam int WORDS_PER_LINE   = 8;    // 32-bit words per line
    localparam int LINE_OFFSET_BITS = 5;    // byte offset inside a line

    localparam int IQ_DEPTH = 8;            // instruction queue entries

    // a line is filled beat by beat and read out word by word
    typedef union packed {
        logic [BEATS_PER_LINE-1:0][63:0] beat;
        logic [WORDS_PER_LINE-1:0][31:0] word;
    } cache_line_u;

    // completed fill handed to the fetch controller
    typedef struct packed {
        logic           valid;
        logic   [31:0]  addr;  // line address of the burst
        cache_line_u    data;
    } line_fill_t;

    // one instruction queue entry
    typedef struct packed {
        logic   [31:0]  pc;
        logic   [31:0]  inst;
    } fetch_entry_t;

endpackage : fetch_pkg

`default_nettype wire

// ==== rtl/cacheline_adapter.sv ====
`timescale 1ns/100ps
`default_nettype none

module cacheline_adapter (
    input   logic                       clk,
    input   logic                       rst,

    input   logic   [63:0]              bmem_rdata_i,
    input   logic   [31:0]              bmem_raddr_i,
    input   logic                       bmem_rvalid_i,

    output  fetch_pkg::line_fill_t      fill_o
);

    logic   [$clog2(fetch_pkg::BEATS_PER_LINE)-1:0] beat_cnt;
    logic                                           last_beat;
    logic                                           fill_valid;
    logic   [31:0]                                  fill_addr;
    fetch_pkg::cache_line_u                         line_q;

    assign last_beat = &beat_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            beat_cnt   <= '0;
            fill_valid <= 1'b0;
        end else begin
            fill_valid <= bmem_rvalid_i && last_beat;   // one cycle after beat 3
            if (bmem_rvalid_i) begin
                beat_cnt <= last_beat ? '0 : beat_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bmem_rvalid_i) begin
            line_q.beat[beat_cnt] <= bmem_rdata_i;
            if (beat_cnt == '0) begin
                fill_addr <= bmem_raddr_i;              // address held from the first beat
            end
        end
    end

    always_comb begin
        fill_o.valid = fill_valid;
        fill_o.addr  = fill_addr;
        fill_o.data  = line_q;
    end

endmodule : cacheline_adapter

`default_nettype wire

// ==== rtl/fetch_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetch_ctrl (
    input   logic                       clk,
    input   logic                       rst,

    input   fetch_pkg::line_fill_t      fill_i,

    input   logic                       bmem_ready_i,
    output  logic   [31:0]              bmem_addr_o,
    output  logic                       bmem_read_o,

    input   logic                       iq_full_i,
    output  logic                       push_o,
    output  fetch_pkg::fetch_entry_t    push_entry_o
);

    logic   [31:0]                                  pc;

    // one-line buffer
    fetch_pkg::cache_line_u                         line_buf;
    logic   [31:fetch_pkg::LINE_OFFSET_BITS]        buf_tag;
    logic                                           buf_valid;

    logic                                           pending;    // line read in flight
    logic                                           hit;
    logic   [$clog2(fetch_pkg::WORDS_PER_LINE)-1:0] word_idx;

    assign word_idx = pc[fetch_pkg::LINE_OFFSET_BITS-1:2];
    assign hit      = buf_valid && (pc[31:fetch_pkg::LINE_OFFSET_BITS] == buf_tag);

    // push only with room in the queue
    assign push_o = hit && !iq_full_i;

    always_comb begin
        push_entry_o.pc   = pc;
        push_entry_o.inst = line_buf.word[word_idx];
    end

    // a miss asks for the line once, and only while memory is ready
    assign bmem_read_o = bmem_ready_i && !hit && !pending;
    assign bmem_addr_o = {pc[31:fetch_pkg::LINE_OFFSET_BITS],
                          {fetch_pkg::LINE_OFFSET_BITS{1'b0}}};

    always_ff @(posedge clk) begin
        if (rst) begin
            pc        <= fetch_pkg::RESET_PC;
            buf_valid <= 1'b0;
            pending   <= 1'b0;
        end else begin
            if (push_o) begin
                pc <= pc + 32'd4;                       // held while the queue is full
            end

            if (bmem_read_o) begin
                pending <= 1'b1;
            end else if (fill_i.valid) begin
                pending <= 1'b0;
            end

            if (fill_i.valid) begin
                buf_valid <= 1'b1;
            end
        end
    end

    // fill replaces the whole buffered line
    always_ff @(posedge clk) begin
        if (fill_i.valid) begin
            line_buf <= fill_i.data;
            buf_tag  <= fill_i.addr[31:fetch_pkg::LINE_OFFSET_BITS];
        end
    end

endmodule : fetch_ctrl

`default_nettype wire

// ==== rtl/inst_queue.sv ====
`timescale 1ns/100ps
`default_nettype none

module inst_queue (
    input   logic                       clk,
    input   logic                       rst,

    input   logic                       push_i,
    input   fetch_pkg::fetch_entry_t    push_entry_i,

    input   logic                       deq_i,
    output  fetch_pkg::fetch_entry_t    entry_o,

    output  logic                       full_o,
    output  logic                       empty_o
);

    fetch_pkg::fetch_entry_t                        mem [fetch_pkg::IQ_DEPTH];
    logic   [$clog2(fetch_pkg::IQ_DEPTH)-1:0]       wr_ptr;
    logic   [$clog2(fetch_pkg::IQ_DEPTH)-1:0]       rd_ptr;
    logic   [$clog2(fetch_pkg::IQ_DEPTH):0]         count;
    logic                                           push_ok;
    logic                                           pop_ok;

    assign full_o  = count[$clog2(fetch_pkg::IQ_DEPTH)];    // msb only set at IQ_DEPTH
    assign empty_o = (count == '0);
    assign push_ok = push_i && !full_o;
    assign pop_ok  = deq_i && !empty_o;
    assign entry_o = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= wr_ptr + 1'b1;                    // pointers wrap on their own
            end
            if (pop_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push_ok && !pop_ok) begin
                count <= count + 1'b1;
            end else if (pop_ok && !push_ok) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem[wr_ptr] <= push_entry_i;
        end
    end

endmodule : inst_queue

`default_nettype wire

// ==== rtl/fetch_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetch_top (
    input   logic                       clk,
    input   logic                       rst,

    output  logic   [31:0]              bmem_addr_o,
    output  logic                       bmem_read_o,
    input   logic                       bmem_ready_i,

    input   logic   [31:0]              bmem_raddr_i,
    input   logic   [63:0]              bmem_rdata_i,
    input   logic                       bmem_rvalid_i,

    output  fetch_pkg::fetch_entry_t    iq_entry_o,
    output  logic                       iq_empty_o,
    input   logic                       iq_deq_i
);

    fetch_pkg::line_fill_t      fill;
    fetch_pkg::fetch_entry_t    push_entry;
    logic                       push;
    logic                       iq_full;

    cacheline_adapter cacheline_adapter_i (
        .clk            (clk),
        .rst            (rst),
        .bmem_rdata_i   (bmem_rdata_i),
        .bmem_raddr_i   (bmem_raddr_i),
        .bmem_rvalid_i  (bmem_rvalid_i),
        .fill_o         (fill)
    );

    fetch_ctrl fetch_ctrl_i (
        .clk            (clk),
        .rst            (rst),
        .fill_i         (fill),
        .bmem_ready_i   (bmem_ready_i),
        .bmem_addr_o    (bmem_addr_o),
        .bmem_read_o    (bmem_read_o),
        .iq_full_i      (iq_full),
        .push_o         (push),
        .push_entry_o   (push_entry)
    );

    inst_queue inst_queue_i (
        .clk            (clk),
        .rst            (rst),
        .push_i         (push),
        .push_entry_i   (push_entry),
        .deq_i          (iq_deq_i),         // rename side pops the head
        .entry_o        (iq_entry_o),
        .full_o         (iq_full),
        .empty_o        (iq_empty_o)
    );

endmodule : fetch_top

`default_nettype wire

// ==== test/bmem_model.sv ====
`timescale 1ns/100ps
`default_nettype none

module bmem_model (
    input   logic           clk,
    input   logic           rst,
    input   logic           slow_i,
    input   logic           read_i,
    input   logic   [31:0]  addr_i,
    output  logic           ready_o,
    output  logic   [31:0]  raddr_o,
    output  logic   [63:0]  rdata_o,
    output  logic           rvalid_o
);

    localparam logic [31:0] DATA_XOR = 32'h5a5a_0000;

    logic           ready_q  = 1'b0;
    logic           rvalid_q = 1'b0;
    logic   [31:0]  raddr_q  = '0;
    logic   [63:0]  rdata_q  = '0;
    logic   [31:0]  req_addr = '0;
    logic           busy     = 1'b0;
    int             req_seen = 0;   // requests taken at posedge
    int             req_done = 0;   // bursts finished
    int             wait_cnt = 0;
    int             beat     = 0;

    assign ready_o  = ready_q;
    assign rvalid_o = rvalid_q;
    assign raddr_o  = raddr_q;
    assign rdata_o  = rdata_q;

    // word at byte address a is a xor DATA_XOR, low word first in a beat
    function automatic logic [63:0] beat_data(input logic [31:0] line, input int idx);
        logic [31:0] a;
        a = line + 32'(idx * 8);
        return {(a + 32'd4) ^ DATA_XOR, a ^ DATA_XOR};
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            req_seen <= 0;
        end else if (read_i && ready_q) begin
            req_addr <= addr_i;
            req_seen <= req_seen + 1;
        end
    end

    always @(negedge clk) begin
        if (rst) begin
            ready_q  <= 1'b0;
            rvalid_q <= 1'b0;
            busy     <= 1'b0;
            req_done <= 0;
        end else begin
            ready_q  <= slow_i ? ($urandom_range(3, 0) == 0) : 1'b1;
            rvalid_q <= 1'b0;
            if (!busy && req_seen != req_done) begin
                busy     <= 1'b1;
                beat     <= 0;
                wait_cnt <= slow_i ? $urandom_range(12, 2) : $urandom_range(5, 1);
            end else if (busy && wait_cnt > 0) begin
                wait_cnt <= wait_cnt - 1;
            end else if (busy) begin
                rvalid_q <= 1'b1;
                raddr_q  <= req_addr;
                rdata_q  <= beat_data(req_addr, beat);
                if (beat == 3) begin
                    busy     <= 1'b0;
                    req_done <= req_done + 1;
                end else begin
                    beat     <= beat + 1;
                    wait_cnt <= slow_i ? $urandom_range(3, 0) : $urandom_range(1, 0);
                end
            end
        end
    end

endmodule : bmem_model

`default_nettype wire

// ==== test/fetch_assert.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetch_assert (
    input   logic   clk,
    input   logic   rst,
    input   logic   bmem_read_o,
    input   logic   bmem_ready_i,
    input   logic   iq_deq_i,
    input   logic   iq_empty_o
);

    read_needs_ready: assert property (@(posedge clk) disable iff (rst)
        bmem_read_o |-> bmem_ready_i)
        else $error("bmem read issued while memory not ready");

    read_is_pulse: assert property (@(posedge clk) disable iff (rst)
        bmem_read_o |=> !bmem_read_o)
        else $error("bmem read held high for two cycles");

    no_pop_when_empty: assert property (@(posedge clk) disable iff (rst)
        iq_deq_i |-> !iq_empty_o)
        else $error("instruction queue popped while empty");

endmodule : fetch_assert

bind fetch_top fetch_assert fetch_assert_i (
    .clk            (clk),
    .rst            (rst),
    .bmem_read_o    (bmem_read_o),
    .bmem_ready_i   (bmem_ready_i),
    .iq_deq_i       (iq_deq_i),
    .iq_empty_o     (iq_empty_o)
);

`default_nettype wire

// ==== test/fetch_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetch_tb;

    localparam logic [31:0] DATA_XOR = 32'h5a5a_0000;
    localparam logic [31:0] LINE0    = fetch_pkg::RESET_PC &
                                       ~((32'd1 << fetch_pkg::LINE_OFFSET_BITS) - 32'd1);
    localparam int STREAM_WORDS  = 40;
    localparam int BP_WORDS      = 24;
    localparam int SLOW_WORDS    = 40;
    localparam int SETTLE_CYCLES = 40;
    localparam int STALL_CYCLES  = 100;
    localparam int LINE_WORST    = 64;  // worst cycles per line with slow memory
    localparam int TEST_CYCLES   = 8 + SETTLE_CYCLES + STALL_CYCLES +
        ((STREAM_WORDS + BP_WORDS + SLOW_WORDS) / fetch_pkg::WORDS_PER_LINE + 6) * LINE_WORST;
    localparam int MARGIN        = 4;

    logic                       clk = 1'b0;
    logic                       rst;
    logic                       slow;
    logic                       iq_deq;
    logic                       bmem_ready;
    logic                       bmem_rvalid;
    logic                       bmem_read;
    logic   [31:0]              bmem_raddr;
    logic   [31:0]              bmem_addr;
    logic   [63:0]              bmem_rdata;
    fetch_pkg::fetch_entry_t    iq_entry;
    logic                       iq_empty;
    logic   [31:0]              exp_pc;     // next pc expected at the queue head
    logic   [31:0]              next_line;  // next line address expected on bmem
    int                         read_cnt;

    always #2 clk = ~clk;

    fetch_top fetch_top_i (
        .clk            (clk),
        .rst            (rst),
        .bmem_addr_o    (bmem_addr),
        .bmem_read_o    (bmem_read),
        .bmem_ready_i   (bmem_ready),
        .bmem_raddr_i   (bmem_raddr),
        .bmem_rdata_i   (bmem_rdata),
        .bmem_rvalid_i  (bmem_rvalid),
        .iq_entry_o     (iq_entry),
        .iq_empty_o     (iq_empty),
        .iq_deq_i       (iq_deq)
    );

    bmem_model bmem_i (
        .clk        (clk),
        .rst        (rst),
        .slow_i     (slow),
        .read_i     (bmem_read),
        .addr_i     (bmem_addr),
        .ready_o    (bmem_ready),
        .raddr_o    (bmem_raddr),
        .rdata_o    (bmem_rdata),
        .rvalid_o   (bmem_rvalid)
    );

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic compare(input string name, input logic [63:0] actual,
                           input logic [63:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("mismatch %s: got 0x%0h, expected 0x%0h",
                                name, actual, expected));
        end
    endtask

    // lines from the reset line up to the one holding pc
    function automatic int lines_touched(input logic [31:0] pc);
        return int'((pc - LINE0) >> fetch_pkg::LINE_OFFSET_BITS) + 1;
    endfunction

    // pop while not empty and check each entry against the data rule
    task automatic drain_entries(input int count);
        int got;
        int cycles;
        got    = 0;
        cycles = 0;
        while (got < count) begin
            @(negedge clk);
            iq_deq <= !iq_empty;
            @(posedge clk);
            if (iq_deq && !iq_empty) begin
                compare("iq_entry_o.pc", 64'(iq_entry.pc), 64'(exp_pc));
                compare("iq_entry_o.inst", 64'(iq_entry.inst), 64'(exp_pc ^ DATA_XOR));
                exp_pc = exp_pc + 32'd4;
                got++;
            end
            cycles++;
            if (cycles > (count / fetch_pkg::WORDS_PER_LINE + 2) * LINE_WORST) begin
                abort_run("instruction stream stalled, no entry arrived in time");
            end
        end
        @(negedge clk);
        iq_deq <= 1'b0;
    endtask

    task automatic reset_state();
        int waited;
        waited = 0;
        @(posedge clk);
        compare("iq_empty_o", 64'(iq_empty), 64'd1);
        // the first request comes with the first ready cycle
        while (!bmem_ready) begin
            waited++;
            if (waited > 20) begin
                abort_run("memory never became ready after reset");
            end
            @(posedge clk);
        end
        compare("bmem_read_o", 64'(bmem_read), 64'd1);
        compare("bmem_addr_o", 64'(bmem_addr), 64'(LINE0));
    endtask

    task automatic sequential_stream();
        drain_entries(STREAM_WORDS);
    endtask

    // queue full, so the pc sits just past the queued words
    task automatic line_request_count();
        repeat (SETTLE_CYCLES) @(posedge clk);
        compare("bmem read count", 64'(read_cnt),
                64'(lines_touched(exp_pc + 32'(4 * fetch_pkg::IQ_DEPTH))));
    endtask

    task automatic backpressure_hold();
        repeat (STALL_CYCLES) @(posedge clk);
        compare("iq_empty_o", 64'(iq_empty), 64'd0);
        compare("bmem read count", 64'(read_cnt),
                64'(lines_touched(exp_pc + 32'(4 * fetch_pkg::IQ_DEPTH))));
        drain_entries(BP_WORDS);
    endtask

    task automatic slow_memory_stream();
        @(negedge clk);
        slow <= 1'b1;
        drain_entries(SLOW_WORDS);
        slow <= 1'b0;
    endtask

    // every read must find memory ready and ask for the next line in order
    always @(posedge clk) begin
        if (rst) begin
            read_cnt  <= 0;
            next_line <= LINE0;
        end else if (bmem_read) begin
            compare("bmem_ready_i", 64'(bmem_ready), 64'd1);
            compare("bmem_addr_o", 64'(bmem_addr), 64'(next_line));
            next_line <= next_line + 32'd32;
            read_cnt  <= read_cnt + 1;
        end
    end

    initial begin
        repeat (MARGIN * TEST_CYCLES) @(posedge clk);
        abort_run("watchdog timeout, the tests did not finish in time");
    end

    initial begin
        void'($urandom(32'h90bc_7dc8));
        rst    = 1'b1;
        slow   = 1'b0;
        iq_deq = 1'b0;
        exp_pc = fetch_pkg::RESET_PC;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst <= 1'b0;

        reset_state();
        sequential_stream();
        line_request_count();
        backpressure_hold();
        slow_memory_stream();

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule : fetch_tb

`default_nettype wire

// ==== sources.f ====
rtl/fetch_pkg.sv
rtl/cacheline_adapter.sv
rtl/fetch_ctrl.sv
rtl/inst_queue.sv
rtl/fetch_top.sv
test/bmem_model.sv
test/fetch_assert.sv
test/fetch_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -f sources.f --top-module fetch_tb \
        -Mdir obj_dir -o fetch_tb_sim; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/fetch_tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST RESULT: PASS$" "$LOG"; then
    exit 0
fi

echo "pass line not found in $LOG"
exit 1
